//--- gauss_defs.svh
`ifndef GAUSS_DEFS_SVH
`define GAUSS_DEFS_SVH

// pixel geometry
`define PIX_W 8

// pixels filtered per cycle, one strip
`define LANES 16

// strips across one image row
`define STRIPS 40

// image height
`define ROWS 480

// one memory word holds a whole row
`define ROW_W (`LANES * `STRIPS * `PIX_W)

// row address and strip index widths
`define ADDR_W 9
`define COL_W 6

`endif

//--- blur_data_pkg.sv
`include "gauss_defs.svh"

package blur_data_pkg;

  typedef logic [`PIX_W-1:0] pixel_t;

  // lane 0 sits in the low bits
  typedef pixel_t [`LANES-1:0] lane_row_t;

  // strip slice with one halo pixel per side
  // index 0 is the left halo, index LANES+1 the right one
  typedef pixel_t [`LANES+1:0] window_row_t;

  typedef struct packed {
    window_row_t top;
    window_row_t mid;
    window_row_t bot;
  } window_t;

  // strip s occupies bits [s*LANES*PIX_W +: LANES*PIX_W]
  typedef logic [`ROW_W-1:0] row_word_t;

endpackage

//--- blur_ctrl_pkg.sv
`include "gauss_defs.svh"

package blur_ctrl_pkg;

  typedef enum logic [1:0] {
    st_idle,
    st_first_strip,
    st_next_strip,
    st_rows
  } seq_state_e;

  typedef logic [`COL_W-1:0]  strip_idx_t;
  typedef logic [`ADDR_W-1:0] row_addr_t;

  // sequencer to write-back control
  typedef struct packed {
    logic strip_clear;
    logic buffer_we;
  } seq_ctrl_t;

  // blur SRAM port, read and write addresses are independent
  typedef struct packed {
    logic                     we;
    row_addr_t                addr_w;
    row_addr_t                addr_r;
    blur_data_pkg::row_word_t din;
  } blur_req_t;

endpackage

//--- blur_sequencer.sv
`timescale 1ns/100ps
`include "gauss_defs.svh"

module blur_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      row_done,
  output blur_ctrl_pkg::row_addr_t  img_addr,
  output logic                      buffer_we,
  output logic                      fill_zero,
  output blur_ctrl_pkg::strip_idx_t strip,
  output logic                      done,
  output blur_ctrl_pkg::seq_ctrl_t  seq_ctrl
);

  import blur_ctrl_pkg::*;

  seq_state_e state;
  seq_state_e state_nxt;

  // pushes already made in this strip, the leading zero row counts as one
  row_addr_t  push_cnt;
  logic       strip_start;
  logic       last_strip;

  assign strip_start = (state == st_first_strip) || (state == st_next_strip);
  assign last_strip  = (strip == strip_idx_t'(`STRIPS - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_first_strip;
        end
      end
      st_first_strip,
      st_next_strip: begin
        state_nxt = st_rows;
      end
      st_rows: begin
        // wait for the write-back side to drain the strip
        if (row_done) begin
          state_nxt = last_strip ? st_idle : st_next_strip;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      strip <= '0;
      done  <= 1'b0;
    end else if (state == st_idle && start) begin
      strip <= '0;
      done  <= 1'b0;
    end else if (state == st_rows && row_done) begin
      if (last_strip) begin
        done <= 1'b1;
      end else begin
        strip <= strip + strip_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push_cnt <= '0;
    end else if (strip_start) begin
      push_cnt <= row_addr_t'(1);
    end else if (buffer_we) begin
      push_cnt <= push_cnt + row_addr_t'(1);
    end
  end

  // address k goes out while row k-1, read last cycle, is pushed
  always_comb begin
    buffer_we = 1'b0;
    fill_zero = 1'b0;
    img_addr  = '0;
    if (strip_start) begin
      // leading zero row, row 0 address goes out alongside
      buffer_we = 1'b1;
      fill_zero = 1'b1;
    end else if (state == st_rows) begin
      if (push_cnt <= `ROWS + 1) begin
        buffer_we = 1'b1;
      end
      // trailing zero row
      if (push_cnt == `ROWS + 1) begin
        fill_zero = 1'b1;
      end
      if (push_cnt < `ROWS) begin
        img_addr = push_cnt;
      end
    end
  end

  assign seq_ctrl.strip_clear = strip_start;
  assign seq_ctrl.buffer_we   = buffer_we;

endmodule

//--- blur_wb_ctrl.sv
`timescale 1ns/100ps
`include "gauss_defs.svh"

module blur_wb_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  blur_ctrl_pkg::seq_ctrl_t seq_ctrl,
  output blur_ctrl_pkg::row_addr_t addr_r,
  output blur_ctrl_pkg::row_addr_t addr_w,
  output logic                     we,
  output logic                     merge_en,
  output logic                     row_done
);

  import blur_ctrl_pkg::*;

  // window after push p is centred on row p-3
  localparam row_addr_t WIN_LAG = row_addr_t'(3);

  row_addr_t push_cnt;
  logic      push_d;
  logic      rd_valid;

  // stage 1 lines up with kernel output and blur_dout
  logic      s1_valid;
  row_addr_t s1_addr;

  // stage 2 is the write cycle
  logic      s2_valid;
  row_addr_t s2_addr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push_cnt <= '0;
      push_d   <= 1'b0;
    end else begin
      push_d <= seq_ctrl.buffer_we;
      if (seq_ctrl.strip_clear) begin
        push_cnt <= row_addr_t'(1);
      end else if (seq_ctrl.buffer_we) begin
        push_cnt <= push_cnt + row_addr_t'(1);
      end
    end
  end

  // a fresh window is on the line buffer outputs
  assign rd_valid = push_d && (push_cnt >= WIN_LAG);
  assign addr_r   = rd_valid ? push_cnt - WIN_LAG : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_addr  <= '0;
      s2_valid <= 1'b0;
      s2_addr  <= '0;
      row_done <= 1'b0;
    end else begin
      s1_valid <= rd_valid;
      s1_addr  <= addr_r;
      s2_valid <= s1_valid;
      s2_addr  <= s1_addr;
      // last row of the strip just written
      row_done <= s2_valid && (s2_addr == row_addr_t'(`ROWS - 1));
    end
  end

  assign merge_en = s1_valid;
  assign we       = s2_valid;
  assign addr_w   = s2_addr;

endmodule

//--- gauss_3x3_kernel.sv
`timescale 1ns/100ps
`include "gauss_defs.svh"

module gauss_3x3_kernel (
  input  logic                     clk,
  input  logic                     rst_n,
  input  blur_data_pkg::window_t   window,
  output blur_data_pkg::lane_row_t lane_result
);

  import blur_data_pkg::*;

  // one 1-2-1 row sum tops out at 4 x 255
  localparam int ROW_SUM_W = `PIX_W + 2;
  // full 3x3 sum plus rounding tops out at 16 x 255 + 8
  localparam int SUM_W     = `PIX_W + 4;
  localparam logic [SUM_W-1:0] ROUND = SUM_W'(8);

  lane_row_t result_nxt;

  function automatic logic [ROW_SUM_W-1:0] tap_sum(
    input pixel_t a,
    input pixel_t b,
    input pixel_t c
  );
    return ROW_SUM_W'(a) + (ROW_SUM_W'(b) << 1) + ROW_SUM_W'(c);
  endfunction

  // lane i reads halo-extended columns i, i+1 and i+2
  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    logic [ROW_SUM_W-1:0] top_sum;
    logic [ROW_SUM_W-1:0] mid_sum;
    logic [ROW_SUM_W-1:0] bot_sum;
    logic [SUM_W-1:0]     total;

    assign top_sum = tap_sum(window.top[i], window.top[i+1], window.top[i+2]);
    assign mid_sum = tap_sum(window.mid[i], window.mid[i+1], window.mid[i+2]);
    assign bot_sum = tap_sum(window.bot[i], window.bot[i+1], window.bot[i+2]);

    // vertical 1-2-1 on the row sums
    assign total = SUM_W'(top_sum) + (SUM_W'(mid_sum) << 1) + SUM_W'(bot_sum) + ROUND;

    // divide by 16
    assign result_nxt[i] = total[SUM_W-1:4];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_result <= '0;
    end else begin
      lane_result <= result_nxt;
    end
  end

endmodule

//--- column_merge.sv
`timescale 1ns/100ps
`include "gauss_defs.svh"

module column_merge (
  input  logic                      clk,
  input  logic                      rst_n,
  input  blur_data_pkg::lane_row_t  lane_result,
  input  blur_data_pkg::row_word_t  blur_dout,
  input  blur_ctrl_pkg::strip_idx_t strip,
  input  logic                      merge_en,
  output blur_data_pkg::row_word_t  din
);

  import blur_data_pkg::*;

  localparam int SLOT_W = `LANES * `PIX_W;

  row_word_t merged;

  // earlier strips come back from memory, later ones stay zero
  always_comb begin
    merged = '0;
    for (int s = 0; s < `STRIPS; s++) begin
      if (s < strip) begin
        merged[s*SLOT_W +: SLOT_W] = blur_dout[s*SLOT_W +: SLOT_W];
      end else if (s == strip) begin
        merged[s*SLOT_W +: SLOT_W] = lane_result;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      din <= '0;
    end else if (merge_en) begin
      din <= merged;
    end
  end

endmodule

//--- gauss_blur_top.sv
`timescale 1ns/100ps

module gauss_blur_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  blur_data_pkg::window_t    window,
  input  blur_data_pkg::row_word_t  blur_dout,
  output logic                      done,
  output blur_ctrl_pkg::row_addr_t  img_addr,
  output logic                      buffer_we,
  output logic                      fill_zero,
  output blur_ctrl_pkg::strip_idx_t strip,
  output blur_ctrl_pkg::blur_req_t  blur_req
);

  import blur_data_pkg::*;
  import blur_ctrl_pkg::*;

  seq_ctrl_t seq_ctrl;
  logic      row_done;
  row_addr_t addr_r;
  row_addr_t addr_w;
  logic      we;
  logic      merge_en;
  lane_row_t lane_result;
  row_word_t din;

  blur_sequencer u_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .row_done  (row_done),
    .img_addr  (img_addr),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .strip     (strip),
    .done      (done),
    .seq_ctrl  (seq_ctrl)
  );

  blur_wb_ctrl u_wb_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .seq_ctrl (seq_ctrl),
    .addr_r   (addr_r),
    .addr_w   (addr_w),
    .we       (we),
    .merge_en (merge_en),
    .row_done (row_done)
  );

  gauss_3x3_kernel u_kernel (
    .clk         (clk),
    .rst_n       (rst_n),
    .window      (window),
    .lane_result (lane_result)
  );

  column_merge u_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_result (lane_result),
    .blur_dout   (blur_dout),
    .strip       (strip),
    .merge_en    (merge_en),
    .din         (din)
  );

  // blur SRAM port
  assign blur_req.we     = we;
  assign blur_req.addr_w = addr_w;
  assign blur_req.addr_r = addr_r;
  assign blur_req.din    = din;

endmodule

//--- tb_gauss_blur.sv
`timescale 1ns/100ps
`include "gauss_defs.svh"

module tb_gauss_blur;

  import blur_data_pkg::*;
  import blur_ctrl_pkg::*;

  localparam int SLOT_W = `LANES * `PIX_W;
  localparam int COLS   = `LANES * `STRIPS;

  logic       clk;
  logic       rst_n;
  logic       start;
  window_t    window;
  row_word_t  blur_dout;
  logic       done;
  row_addr_t  img_addr;
  logic       buffer_we;
  logic       fill_zero;
  strip_idx_t strip;
  blur_req_t  blur_req;

  row_word_t img_mem [`ROWS];
  row_word_t blur_mem [`ROWS];
  row_word_t ref_mem [`ROWS];
  row_word_t first_run [`ROWS];
  row_word_t img_dout;
  row_word_t lb_top;
  row_word_t lb_mid;
  row_word_t lb_bot;

  integer seed;
  int     error_count;
  int     tests_run;
  int     tests_failed;
  int     wr_cnt;
  int     strips_seen;
  int     total_writes;
  bit     timed_out;
  bit     done_prev;

  gauss_blur_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .window    (window),
    .blur_dout (blur_dout),
    .done      (done),
    .img_addr  (img_addr),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .strip     (strip),
    .blur_req  (blur_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // image SRAM, blur SRAM and three-row line buffer
  always @(posedge clk) begin
    img_dout  <= img_mem[img_addr];
    blur_dout <= blur_mem[blur_req.addr_r];
    if (blur_req.we) begin
      blur_mem[blur_req.addr_w] <= blur_req.din;
    end
    if (buffer_we) begin
      lb_top <= lb_mid;
      lb_mid <= lb_bot;
      lb_bot <= fill_zero ? '0 : img_dout;
    end
  end

  // strip slice with zero halo outside the image
  function automatic window_row_t slice_row(input row_word_t row, input strip_idx_t s);
    window_row_t slice;
    int          col;
    for (int i = 0; i < `LANES + 2; i++) begin
      col = int'(s) * `LANES + i - 1;
      slice[i] = (col < 0 || col >= COLS) ? '0 : row[col*`PIX_W +: `PIX_W];
    end
    return slice;
  endfunction

  assign window.top = slice_row(lb_top, strip);
  assign window.mid = slice_row(lb_mid, strip);
  assign window.bot = slice_row(lb_bot, strip);

  function automatic int image_pixel(input int r, input int c);
    if (r < 0 || r >= `ROWS || c < 0 || c >= COLS) begin
      return 0;
    end
    return int'(img_mem[r][c*`PIX_W +: `PIX_W]);
  endfunction

  // 1-2-1 by 1-2-1 weights, zero outside the image, round then divide by 16
  task automatic build_reference();
    int sum;
    for (int r = 0; r < `ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * image_pixel(r + dr, c + dc);
          end
        end
        ref_mem[r][c*`PIX_W +: `PIX_W] = pixel_t'((sum + 8) >> 4);
      end
    end
  endtask

  // each 16-bit chunk carries the whole row address
  task automatic fill_blur_memory();
    for (int a = 0; a < `ROWS; a++) begin
      blur_mem[a] = {(`ROW_W / 16){7'h4b, row_addr_t'(a)}};
    end
  endtask

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_write();
    row_word_t word;
    row_word_t old_word;
    row_addr_t row;
    word     = blur_req.din;
    row      = blur_req.addr_w;
    old_word = blur_mem[row];
    if (strips_seen >= `STRIPS) begin
      report_fail($sformatf("blur write to row %0d after the last strip", row));
      return;
    end
    assert (row == row_addr_t'(wr_cnt))
      else report_fail($sformatf("strip %0d write %0d went to row %0d", strips_seen, wr_cnt, row));
    assert (strip == strip_idx_t'(strips_seen))
      else report_fail($sformatf("strip is %0d, expected %0d", strip, strips_seen));
    for (int s = 0; s < `STRIPS; s++) begin
      if (s < strips_seen) begin
        assert (word[s*SLOT_W +: SLOT_W] == old_word[s*SLOT_W +: SLOT_W])
          else report_fail($sformatf("row %0d slot %0d lost its earlier value", row, s));
      end else if (s == strips_seen) begin
        assert (word[s*SLOT_W +: SLOT_W] == ref_mem[wr_cnt][s*SLOT_W +: SLOT_W])
          else report_fail($sformatf("row %0d slot %0d differs from reference", wr_cnt, s));
      end else begin
        assert (word[s*SLOT_W +: SLOT_W] == '0)
          else report_fail($sformatf("row %0d slot %0d not zero", row, s));
      end
    end
    wr_cnt++;
    total_writes++;
    if (wr_cnt == `ROWS) begin
      wr_cnt = 0;
      strips_seen++;
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (blur_req.we) begin
        check_write();
      end
      if (done && !done_prev) begin
        assert (strips_seen == `STRIPS)
          else report_fail($sformatf("done rose after %0d strips", strips_seen));
      end
    end
    done_prev = done;
  end

  task automatic pulse_start();
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
  endtask

  task automatic wait_for_strip(input int value, input int limit);
    int cycles;
    cycles = 0;
    while (strip != strip_idx_t'(value) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (strip != strip_idx_t'(value)) begin
      $display("timeout: strip %0d not reached within %0d cycles", value, limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_for_done(input int limit);
    int cycles;
    cycles = 0;
    while (!done && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout: done did not rise within %0d cycles", limit);
      timed_out = 1'b1;
    end
  endtask

  // optionally pokes start again while strip 3 is running
  task automatic run_image(input bit busy_start);
    pulse_start();
    wr_cnt       = 0;
    strips_seen  = 0;
    total_writes = 0;
    if (busy_start) begin
      wait_for_strip(3, 5000);
      if (!timed_out) begin
        pulse_start();
      end
    end
    if (!timed_out) begin
      wait_for_done(25000);
    end
    assert (total_writes == `ROWS * `STRIPS)
      else report_fail($sformatf("%0d blur writes in the run", total_writes));
  endtask

  task automatic compare_memory(input bit against_first);
    row_word_t expected;
    for (int r = 0; r < `ROWS; r++) begin
      expected = against_first ? first_run[r] : ref_mem[r];
      assert (blur_mem[r] == expected)
        else report_fail($sformatf("blur memory row %0d wrong after the run", r));
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before && !timed_out) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               error_count - errors_before);
    end
  endtask

  initial begin
    int mark;
    seed         = 32'h974a;
    rst_n        = 1'b0;
    start        = 1'b0;
    img_dout     = '0;
    blur_dout    = '0;
    lb_top       = '0;
    lb_mid       = '0;
    lb_bot       = '0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    done_prev    = 1'b0;
    for (int r = 0; r < `ROWS; r++) begin
      for (int k = 0; k < `ROW_W / 32; k++) begin
        img_mem[r][k*32 +: 32] = $random(seed);
      end
    end
    build_reference();
    fill_blur_memory();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    mark = error_count;
    repeat (3) begin
      @(negedge clk);
      assert (!done && !buffer_we && !fill_zero && !blur_req.we)
        else report_fail("control outputs not low while idle");
      assert (img_addr == '0 && strip == '0)
        else report_fail($sformatf("img_addr %0d strip %0d while idle", img_addr, strip));
    end
    finish_test("idle after reset", mark);

    mark = error_count;
    run_image(1'b1);
    compare_memory(1'b0);
    first_run = blur_mem;
    finish_test("full image with busy start", mark);

    mark = error_count;
    repeat (40) begin
      @(negedge clk);
      assert (done) else report_fail("done dropped without a start");
    end
    finish_test("done holds", mark);

    mark = error_count;
    if (!timed_out) begin
      fill_blur_memory();
      run_image(1'b0);
      compare_memory(1'b1);
    end
    finish_test("second run", mark);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- gauss_blur_top.f
+incdir+.
blur_data_pkg.sv
blur_ctrl_pkg.sv
blur_sequencer.sv
blur_wb_ctrl.sv
gauss_3x3_kernel.sv
column_merge.sv
gauss_blur_top.sv
tb_gauss_blur.sv

//--- Bender.yml
package:
  name: gauss_blur

export_include_dirs:
  - .

sources:
  - files:
      - blur_data_pkg.sv
      - blur_ctrl_pkg.sv
      - blur_sequencer.sv
      - blur_wb_ctrl.sv
      - gauss_3x3_kernel.sv
      - column_merge.sv
      - gauss_blur_top.sv
  - target: test
    files:
      - tb_gauss_blur.sv
